// ==== flist.f ====
hdl/cpuPkg.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/aluFlags.sv
hdl/pcUnit.sv
hdl/instrMem.sv
hdl/dataMem.sv
hdl/cpuTop.sv
test/cpuTb.sv

// ==== hdl/aluFlags.sv ====
`timescale 1ns/1ps

module aluFlags (
	input logic clk,
	input logic rstN,
	input logic run,
	input cpuPkg::ctrlT ctrl,
	input logic [cpuPkg::dataWidth-1:0] rdData1,
	input logic [cpuPkg::dataWidth-1:0] rdData2,
	output logic [cpuPkg::dataWidth-1:0] aluResult,
	output logic zFlag
);

	logic sumZero;
	logic flagUpdate;

	// Single operation that wraps at word width
	assign aluResult = rdData1 + rdData2;
	assign sumZero = (aluResult == '0);

	// Only a committed ADD touches the flag
	// LD, ST and BRZ leave it alone
	assign flagUpdate = run && ctrl.aluOp;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			zFlag <= 1'b0;
		end else if (flagUpdate) begin
			zFlag <= sumZero;
		end
	end

endmodule

// ==== hdl/cpuPkg.sv ====
package cpuPkg;

	localparam int dataWidth = 16;      // Machine word
	localparam int regSelBits = 2;      // Four registers
	localparam int addrFieldBits = 11;  // Width of the LD/ST/BRZ address field and cap on dmemAddrBits

	typedef enum logic [1:0] {
		opAdd = 2'b00,
		opLd  = 2'b01,
		opSt  = 2'b10,
		opBrz = 2'b11
	} opcodeT;

	// Register form for ADD and the register-addressed variants
	typedef struct packed {
		opcodeT op;                   // [15:14]
		logic [regSelBits-1:0] rd;    // [13:12]
		logic [regSelBits-1:0] rs1;   // [11:10]
		logic [regSelBits-1:0] rs2;   // [9:8]
		logic [6:0] unused;           // [7:1]
		logic mode;                   // 0 absolute/relative, 1 register
	} instrRegT;

	// Address form whose addr overlaps rs1, rs2 and the unused bits
	typedef struct packed {
		opcodeT op;
		logic [regSelBits-1:0] rd;
		logic [addrFieldBits-1:0] addr;  // Zero- or sign-extended by the decoder
		logic mode;
	} instrAddrT;

	typedef union packed {
		instrRegT regForm;
		instrAddrT addrForm;
	} instrU;

	typedef enum logic [1:0] {
		pcInc = 2'b00,
		pcRel = 2'b01,
		pcReg = 2'b10  // 2'b11 never decoded
	} pcSelT;

	typedef struct packed {
		pcSelT pcSel;
		logic regInSource;                  // 0 ALU, 1 memory
		logic regFileWe;
		logic [regSelBits-1:0] regInSel;    // Write-back register
		logic [regSelBits-1:0] regOutSel1;
		logic [regSelBits-1:0] regOutSel2;
		logic aluOp;                        // Set for ADD and gates the zero flag
		logic dWe;
		logic dAddrSel;                     // 0 address field, 1 read port 1
	} ctrlT;

	// One trace item per committed write
	typedef struct packed {
		logic valid;
		logic [regSelBits-1:0] regNum;
		logic [dataWidth-1:0] data;
	} regWriteT;

	typedef struct packed {
		logic valid;
		logic [dataWidth-1:0] addr;
		logic [dataWidth-1:0] data;
	} memWriteT;

endpackage

// ==== hdl/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop #(
	parameter int imemAddrBits = 8,
	parameter int dmemAddrBits = 11
) (
	input logic clk,
	input logic rstN,
	input logic run,                           // Low stalls everything
	input logic imemWe,
	input logic [imemAddrBits-1:0] imemAddr,
	input logic [cpuPkg::dataWidth-1:0] imemData,
	output cpuPkg::regWriteT regTrace,
	output cpuPkg::memWriteT memTrace
);
	import cpuPkg::*;

	instrU instr;
	ctrlT ctrl;
	logic [dataWidth-1:0] addr;        // From the decoder
	logic [dataWidth-1:0] rdData1;
	logic [dataWidth-1:0] rdData2;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] memData;
	logic zFlag;
	logic [imemAddrBits-1:0] pc;

	instrMem #(.imemAddrBits(imemAddrBits)) instrMem0 (
		.clk(clk),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.pc(pc),
		.instr(instr)
	);

	instrDecoder instrDecoder0 (
		.instr(instr),
		.zFlag(zFlag),
		.ctrl(ctrl),
		.addr(addr)
	);

	regFile regFile0 (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.ctrl(ctrl),
		.aluResult(aluResult),
		.memData(memData),
		.rdData1(rdData1),
		.rdData2(rdData2),
		.regTrace(regTrace)
	);

	aluFlags aluFlags0 (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.ctrl(ctrl),
		.rdData1(rdData1),
		.rdData2(rdData2),
		.aluResult(aluResult),
		.zFlag(zFlag)
	);

	pcUnit #(.imemAddrBits(imemAddrBits)) pcUnit0 (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.ctrl(ctrl),
		.addr(addr),
		.rdData1(rdData1),
		.pc(pc)
	);

	dataMem #(.dmemAddrBits(dmemAddrBits)) dataMem0 (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.ctrl(ctrl),
		.addr(addr),
		.rdData1(rdData1),
		.rdData2(rdData2),
		.memData(memData),
		.memTrace(memTrace)
	);

endmodule

// ==== hdl/dataMem.sv ====
`timescale 1ns/1ps

module dataMem #(
	parameter int dmemAddrBits = 11  // At most the 11-bit address field
) (
	input logic clk,
	input logic rstN,
	input logic run,
	input cpuPkg::ctrlT ctrl,
	input logic [cpuPkg::dataWidth-1:0] addr,
	input logic [cpuPkg::dataWidth-1:0] rdData1,  // Register address
	input logic [cpuPkg::dataWidth-1:0] rdData2,  // Store data
	output logic [cpuPkg::dataWidth-1:0] memData,
	output cpuPkg::memWriteT memTrace
);
	import cpuPkg::*;

	localparam int depth = 1 << dmemAddrBits;

	logic [dataWidth-1:0] mem [depth] = '{default: '0};  // Starts cleared
	logic [dmemAddrBits-1:0] memAddr;
	logic wrEn;

	// Address field or truncated register value
	assign memAddr = ctrl.dAddrSel ? rdData1[dmemAddrBits-1:0] : addr[dmemAddrBits-1:0];
	assign memData = mem[memAddr];
	assign wrEn = run && ctrl.dWe;

	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[memAddr] <= rdData2;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			memTrace <= '0;
		end else begin
			memTrace.valid <= wrEn;
			memTrace.addr <= {{(dataWidth - dmemAddrBits){1'b0}}, memAddr};
			memTrace.data <= rdData2;
		end
	end

	// Absolute address must not alias through truncation
	assert property (@(posedge clk) disable iff (!rstN)
		wrEn && !ctrl.dAddrSel |-> addr < depth)
	else $error("Absolute store address %0h beyond data memory", addr);

endmodule

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
	input cpuPkg::instrU instr,
	input logic zFlag,                        // Condition for BRZ
	output cpuPkg::ctrlT ctrl,
	output logic [cpuPkg::dataWidth-1:0] addr  // Memory address or branch offset
);
	import cpuPkg::*;

	localparam int extBits = dataWidth - addrFieldBits;

	logic [addrFieldBits-1:0] addrField;
	logic [dataWidth-1:0] addrZext;
	logic [dataWidth-1:0] addrSext;

	assign addrField = instr.addrForm.addr;
	assign addrZext = {{extBits{1'b0}}, addrField};
	assign addrSext = {{extBits{addrField[addrFieldBits-1]}}, addrField};

	always_comb begin
		ctrl = '0;
		ctrl.pcSel = pcInc;
		// Register selects taken straight from the word
		ctrl.regInSel = instr.regForm.rd;
		ctrl.regOutSel1 = instr.regForm.rs1;
		ctrl.regOutSel2 = instr.regForm.rs2;
		addr = '0;

		case (instr.regForm.op)
			opAdd: begin
				ctrl.aluOp = 1'b1;
				ctrl.regFileWe = 1'b1;
			end

			opLd: begin
				ctrl.regInSource = 1'b1;  // Write back from memory
				ctrl.regFileWe = 1'b1;
				if (instr.addrForm.mode) begin
					ctrl.dAddrSel = 1'b1;  // mem[rs1]
				end else begin
					addr = addrZext;
				end
			end

			opSt: begin
				ctrl.dWe = 1'b1;
				if (instr.addrForm.mode) begin
					ctrl.dAddrSel = 1'b1;  // mem[rs1] <- rs2
				end else begin
					// Absolute store writes rd, so read it on port 2
					ctrl.regOutSel2 = instr.regForm.rd;
					addr = addrZext;
				end
			end

			opBrz: begin
				// Not taken falls through to pcInc
				if (zFlag) begin
					if (instr.addrForm.mode) begin
						ctrl.pcSel = pcReg;   // pc <- rs1
					end else begin
						ctrl.pcSel = pcRel;   // pc <- pc + offset
						addr = addrSext;
					end
				end
			end

			default: begin
				ctrl.pcSel = pcInc;
			end
		endcase
	end

endmodule

// ==== hdl/instrMem.sv ====
`timescale 1ns/1ps

module instrMem #(
	parameter int imemAddrBits = 8
) (
	input logic clk,
	input logic imemWe,                          // Load port used only with run low
	input logic [imemAddrBits-1:0] imemAddr,
	input logic [cpuPkg::dataWidth-1:0] imemData,
	input logic [imemAddrBits-1:0] pc,
	output cpuPkg::instrU instr
);
	import cpuPkg::*;

	localparam int depth = 1 << imemAddrBits;

	logic [dataWidth-1:0] mem [depth];

	// Program load
	always_ff @(posedge clk) begin
		if (imemWe) begin
			mem[imemAddr] <= imemData;
		end
	end

	// Combinational fetch with the instruction ready in the same cycle
	assign instr = mem[pc];

endmodule

// ==== hdl/pcUnit.sv ====
`timescale 1ns/1ps

module pcUnit #(
	parameter int imemAddrBits = 8
) (
	input logic clk,
	input logic rstN,
	input logic run,
	input cpuPkg::ctrlT ctrl,
	input logic [cpuPkg::dataWidth-1:0] addr,     // Sign-extended branch offset
	input logic [cpuPkg::dataWidth-1:0] rdData1,  // Register branch target
	output logic [imemAddrBits-1:0] pc
);
	import cpuPkg::*;

	logic [imemAddrBits-1:0] pcNext;

	// Arithmetic at imemAddrBits wraps at the memory size
	always_comb begin
		case (ctrl.pcSel)
			pcRel: begin
				pcNext = pc + addr[imemAddrBits-1:0];
			end
			pcReg: begin
				pcNext = rdData1[imemAddrBits-1:0];  // Upper bits dropped
			end
			default: begin
				pcNext = pc + 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
		end else if (run) begin
			pc <= pcNext;
		end
	end

	// Decoder never emits the spare select code
	assert property (@(posedge clk) disable iff (!rstN)
		run |-> ctrl.pcSel != 2'b11)
	else $error("Unused pcSel encoding at pc %0d", pc);

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic rstN,
	input logic run,
	input cpuPkg::ctrlT ctrl,
	input logic [cpuPkg::dataWidth-1:0] aluResult,
	input logic [cpuPkg::dataWidth-1:0] memData,
	output logic [cpuPkg::dataWidth-1:0] rdData1,
	output logic [cpuPkg::dataWidth-1:0] rdData2,
	output cpuPkg::regWriteT regTrace  // One cycle after the commit edge
);
	import cpuPkg::*;

	localparam int numRegs = 1 << regSelBits;

	logic [dataWidth-1:0] regs [numRegs];
	logic [dataWidth-1:0] wrData;
	logic wrEn;

	assign wrData = ctrl.regInSource ? memData : aluResult;  // Write-back source
	assign wrEn = run && ctrl.regFileWe;

	// Asynchronous reads
	assign rdData1 = regs[ctrl.regOutSel1];
	assign rdData2 = regs[ctrl.regOutSel2];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
			regTrace <= '0;
		end else begin
			if (wrEn) begin
				regs[ctrl.regInSel] <= wrData;
			end
			// Valid only for the cycle after a write
			regTrace.valid <= wrEn;
			regTrace.regNum <= ctrl.regInSel;
			regTrace.data <= wrData;
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the CPU testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module cpuTb --Mdir obj_dir -o cpuSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cpuSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "TEST OK" "$logFile"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

// ==== test/cpuStimulus.txt ====
# I <imem addr> <instruction word>, R <reg> <data>, M <dmem addr> <data>, all hex
# R and M lines list the expected trace events of each kind in order
I 00 C020  # BRZ +16, not taken after reset, taken on the second pass
I 01 9246  # ST r1 -> [123]
I 02 6246  # LD r2 <- [123]
I 03 C010  # BRZ +8, not taken, zFlag kept clear by LD and ST
I 04 3600  # ADD r3 = r1 + r2, zero sets zFlag
I 05 C006  # BRZ +3 forward to 08
I 06 1000  # Skipped ADD r1
I 07 8FFE  # Skipped ST r0 -> [7FF]
I 08 AFFE  # ST r2 -> [7FF]
I 09 5C01  # LD r1 <- [r3]
I 0A 8901  # ST [r2] <- r1
I 0B C001  # BRZ to r0, back to 00 with zFlag still set
I 0C 2F00  # Never reached
I 0D B754  # Never reached
I 0E B0AA  # ST r3 -> [055]
I 0F C006  # BRZ +3 to 12
I 10 0500  # ADD r0 = r1 + r1
I 11 CFFA  # BRZ -3 backward to 0E
I 12 50AA  # LD r1 <- [055]
I 13 3000  # Past the end, run drops first
R 2 0000
R 3 0000
R 1 0000
R 0 0000
R 1 0000
M 0123 0000
M 07FF 0000
M 0000 0000
M 0055 0000

// ==== test/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;
	import cpuPkg::*;

	localparam int imemAddrBits = 8;
	localparam int dmemAddrBits = 11;
	localparam int clkPeriod = 100;
	localparam int resetCycles = 4;
	localparam int cyclesPerEvent = 4;
	localparam int spareCycles = 8;   // Run start and idle check at the end
	localparam string stimFile = "test/cpuStimulus.txt";

	logic clk;
	logic rstN;
	logic run;
	logic imemWe;
	logic [imemAddrBits-1:0] imemAddr;
	logic [dataWidth-1:0] imemData;
	regWriteT regTrace;
	memWriteT memTrace;

	// Program image and expected trace events from the stimulus file
	logic [imemAddrBits-1:0] progAddr [$];
	logic [dataWidth-1:0] progWord [$];
	regWriteT expRegQ [$];
	memWriteT expMemQ [$];
	int watchdogCycles;
	logic stimReady;

	cpuTop #(
		.imemAddrBits(imemAddrBits),
		.dmemAddrBits(dmemAddrBits)
	) dut0 (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.regTrace(regTrace),
		.memTrace(memTrace)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic reportMismatch(input string msg);
		abortRun($sformatf("Mismatch at %0t: %s", $time, msg));
	endtask

	// Compares against the next expected register write in program order
	task automatic checkRegWrite(input regWriteT got);
		regWriteT exp;
		if (expRegQ.size() == 0) begin
			abortRun($sformatf("Unexpected register write r%0d = %h at %0t, none left to expect",
				got.regNum, got.data, $time));
		end else begin
			exp = expRegQ.pop_front();
			if (got.regNum !== exp.regNum || got.data !== exp.data) begin
				reportMismatch($sformatf("register write r%0d = %h, expected r%0d = %h",
					got.regNum, got.data, exp.regNum, exp.data));
			end
		end
	endtask

	task automatic checkMemWrite(input memWriteT got);
		memWriteT exp;
		if (expMemQ.size() == 0) begin
			abortRun($sformatf("Unexpected store [%h] = %h at %0t, none left to expect",
				got.addr, got.data, $time));
		end else begin
			exp = expMemQ.pop_front();
			if (got.addr !== exp.addr || got.data !== exp.data) begin
				reportMismatch($sformatf("store [%h] = %h, expected [%h] = %h",
					got.addr, got.data, exp.addr, exp.data));
			end
		end
	endtask

	// No trace item may show while run is low
	task automatic expectIdle(input string phase);
		if (regTrace.valid || memTrace.valid) begin
			abortRun($sformatf("Trace event at %0t during %s", $time, phase));
		end
	endtask

	// Reads I, R and M records and skips '#' comments
	task automatic readStimulus();
		int fd;
		int code;
		int ch;
		logic [7:0] kind;
		logic [15:0] fieldA;
		logic [15:0] fieldB;
		regWriteT regItem;
		memWriteT memItem;
		bit eof;
		fd = $fopen(stimFile, "r");
		if (fd == 0) begin
			abortRun({"Cannot open the stimulus file ", stimFile});
		end else begin
			eof = 1'b0;
			while (!eof) begin
				code = $fscanf(fd, " %c", kind);
				if (code != 1) begin
					eof = 1'b1;
				end else if (kind == "#") begin
					ch = $fgetc(fd);  // Skip to end of line
					while (ch != "\n" && ch != -1) begin
						ch = $fgetc(fd);
					end
				end else begin
					code = $fscanf(fd, "%h %h", fieldA, fieldB);
					if (code != 2) begin
						abortRun($sformatf("Record '%c' in the stimulus file lacks its fields",
							kind));
					end else begin
						case (kind)
							"I": begin
								progAddr.push_back(fieldA[imemAddrBits-1:0]);
								progWord.push_back(fieldB);
							end
							"R": begin
								regItem.valid = 1'b1;
								regItem.regNum = fieldA[regSelBits-1:0];
								regItem.data = fieldB;
								expRegQ.push_back(regItem);
							end
							"M": begin
								memItem.valid = 1'b1;
								memItem.addr = fieldA;
								memItem.data = fieldB;
								expMemQ.push_back(memItem);
							end
							default: begin
								abortRun($sformatf("Unknown record kind '%c' in the stimulus file",
									kind));
							end
						endcase
					end
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin
		rstN = 1'b0;
		run = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		stimReady = 1'b0;

		readStimulus();
		watchdogCycles = cyclesPerEvent * (expRegQ.size() + expMemQ.size())
			+ progAddr.size() + resetCycles + spareCycles;
		stimReady = 1'b1;

		repeat (resetCycles) @(negedge clk);
		rstN = 1'b1;

		// Load through the port while run holds the core
		foreach (progAddr[i]) begin
			@(negedge clk);
			expectIdle("program load");
			imemWe = 1'b1;
			imemAddr = progAddr[i];
			imemData = progWord[i];
		end
		@(negedge clk);
		imemWe = 1'b0;

		run = 1'b1;
		while (expRegQ.size() + expMemQ.size() > 0) begin
			@(negedge clk);  // Trace registers settled
			if (regTrace.valid) begin
				checkRegWrite(regTrace);
			end
			if (memTrace.valid) begin
				checkMemWrite(memTrace);
			end
		end
		run = 1'b0;  // Stop before the instruction past the end commits

		repeat (2) begin
			@(negedge clk);
			expectIdle("the stall after the program");
		end

		$display("TEST OK");
		$finish;
	end

	// Bound from the stimulus length
	initial begin
		wait (stimReady);
		repeat (watchdogCycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles: the program did not finish", watchdogCycles);
		$display("TEST FAILED");
		$fatal(1, "Run ended by the watchdog");
	end

endmodule
